// File: hw/psg_pkg.sv
// PSG sound block package: sizes, command byte views, attenuation table and register map.
package psg_pkg;

	//////////////////////////////////////////////////////////////////////
	// Sizes
	//////////////////////////////////////////////////////////////////////
	localparam int NUM_CH   = 3;   // Tone channels.
	localparam int TICK_DIV = 48;  // clk48M cycles per tone tick.
	localparam int PER_W    = 10;  // Tone period.
	localparam int ATT_W    = 4;   // Attenuation code.
	localparam int AMP_W    = 14;  // Unsigned channel amplitude.
	localparam int SAMPLE_W = 16;  // Signed PCM sample.
	localparam int ADDR_W   = 4;   // APB address.
	localparam int DATA_W   = 8;   // APB data.

	localparam logic [ATT_W-1:0] ATT_SILENT = 4'hF;  // Mute code.

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////
	localparam logic [ADDR_W-1:0] ADDR_CMD     = 4'd0;  // Command byte.
	localparam logic [ADDR_W-1:0] ADDR_CH_BASE = 4'd8;  // Two bytes per channel.

	// Amplitude per attenuation code, about 2 dB per step.
	// Peak is kept at 10922 so three channels stay inside a signed 16-bit sum.
	localparam logic [AMP_W-1:0] ATT_LUT [16] = '{
		14'd10922, 14'd8675, 14'd6891, 14'd5474,
		14'd4348,  14'd3454, 14'd2743, 14'd2179,
		14'd1731,  14'd1375, 14'd1092, 14'd867,
		14'd689,   14'd547,  14'd435,  14'd0
	};

	//////////////////////////////////////////////////////////////////////
	// Command byte, SN76489 style
	//////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic             latch;  // Set for a latch byte.
		logic [1:0]       ch;     // Target channel.
		logic             typ;    // 0 period, 1 attenuation.
		logic [3:0]       data;   // Period 3:0 or attenuation.
	} psg_latch_t;

	typedef struct packed {
		logic             latch;  // Clear for a data byte.
		logic             rsvd;
		logic [5:0]       data;   // Period 9:4.
	} psg_data_t;

	typedef union packed {
		psg_latch_t lat;
		psg_data_t  dat;
	} psg_cmd_u;

endpackage

// File: hw/psg_tick_gen.sv
// Tone tick generator: one-cycle clock enable every TICK_DIV cycles of clk48M.
module psg_tick_gen (
	input  logic clk48M,
	input  logic reset,
	output logic tick
);

	logic [$clog2(psg_pkg::TICK_DIV)-1:0] cnt;  // Modulo counter.
	logic                                 wrap;

	assign wrap = (cnt == psg_pkg::TICK_DIV - 1);

	// Count 0 .. TICK_DIV-1 and start over.
	always_ff @(posedge clk48M) begin
		if (reset) begin
			cnt <= '0;
		end else if (wrap) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// Registered, so the first pulse lands TICK_DIV edges after reset.
	always_ff @(posedge clk48M) begin
		if (reset) begin
			tick <= 1'b0;
		end else begin
			tick <= wrap;
		end
	end

endmodule

// File: hw/psg_regs.sv
// PSG register file: APB slave decoding SN76489 style command bytes, with readback.
module psg_regs (
	input  logic                                     clk48M,
	input  logic                                     reset,
	input  logic                                     psel,
	input  logic                                     penable,
	input  logic                                     pwrite,
	input  logic [psg_pkg::ADDR_W-1:0]               paddr,
	input  logic [psg_pkg::DATA_W-1:0]               pwdata,
	output logic [psg_pkg::DATA_W-1:0]               prdata,
	output logic [psg_pkg::NUM_CH*psg_pkg::PER_W-1:0] period,
	output logic [psg_pkg::NUM_CH*psg_pkg::ATT_W-1:0] atten
);

	logic [psg_pkg::PER_W-1:0] per_q [psg_pkg::NUM_CH];  // Channel periods.
	logic [psg_pkg::ATT_W-1:0] att_q [psg_pkg::NUM_CH];  // Channel attenuations.

	psg_pkg::psg_cmd_u cmd;       // Incoming byte, both views.
	psg_pkg::psg_cmd_u last_cmd;  // Last accepted latch byte.

	logic wr_cmd;
	logic rd_en;

	assign cmd    = pwdata;
	assign wr_cmd = psel & penable & pwrite & (paddr == psg_pkg::ADDR_CMD);
	assign rd_en  = psel & penable & ~pwrite;

	//////////////////////////////////////////////////////////////////////
	// Command decode
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk48M) begin
		if (reset) begin
			last_cmd <= '0;
			for (int c = 0; c < psg_pkg::NUM_CH; c++) begin
				per_q[c] <= '0;
				att_q[c] <= psg_pkg::ATT_SILENT;
			end
		end else if (wr_cmd) begin
			if (cmd.lat.latch) begin
				// Channel 3 is the noise slot, not built here.
				if (cmd.lat.ch < psg_pkg::NUM_CH) begin
					last_cmd <= cmd;
					if (cmd.lat.typ) begin
						att_q[cmd.lat.ch] <= cmd.lat.data;       // Attenuation.
					end else begin
						per_q[cmd.lat.ch][3:0] <= cmd.lat.data;  // Period low nibble.
					end
				end
			end else begin
				// Data byte goes to the channel of the last latch.
				per_q[last_cmd.lat.ch][psg_pkg::PER_W-1:4] <= cmd.dat.data;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Outputs and readback
	//////////////////////////////////////////////////////////////////////
	genvar g;
	generate
		for (g = 0; g < psg_pkg::NUM_CH; g++) begin : g_flat
			assign period[g*psg_pkg::PER_W +: psg_pkg::PER_W] = per_q[g];
			assign atten[g*psg_pkg::ATT_W +: psg_pkg::ATT_W]  = att_q[g];
		end
	endgenerate

	// Read data only during the access cycle of a read.
	always_comb begin
		prdata = '0;
		if (rd_en) begin
			if (paddr == psg_pkg::ADDR_CMD) begin
				prdata = last_cmd;
			end
			for (int c = 0; c < psg_pkg::NUM_CH; c++) begin
				if (paddr == psg_pkg::ADDR_W'(psg_pkg::ADDR_CH_BASE + 2 * c)) begin
					prdata = per_q[c][7:0];  // Period low byte.
				end
				if (paddr == psg_pkg::ADDR_W'(psg_pkg::ADDR_CH_BASE + 2 * c + 1)) begin
					prdata = {att_q[c], 2'b00, per_q[c][psg_pkg::PER_W-1:8]};
				end
			end
		end
	end

endmodule

// File: hw/psg_tone.sv
// PSG tone channel: period down-counter that flips a square-wave polarity bit.
module psg_tone (
	input  logic                      clk48M,
	input  logic                      reset,
	input  logic                      tick,
	input  logic [psg_pkg::PER_W-1:0] period,
	output logic                      polarity
);

	logic [psg_pkg::PER_W-1:0] cnt;  // Ticks left in this half period.
	logic                      silent;
	logic                      reload;

	assign silent = (period == '0);
	assign reload = (cnt <= 1);  // Also catches a counter parked at zero.

	//////////////////////////////////////////////////////////////////////
	// Half-period counter
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk48M) begin
		if (reset) begin
			cnt      <= '0;
			polarity <= 1'b1;
		end else if (silent) begin
			cnt      <= '0;    // Park until a period arrives.
			polarity <= 1'b1;  // Flat output.
		end else if (tick) begin
			if (reload) begin
				cnt      <= period;  // New period takes effect here.
				polarity <= ~polarity;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

endmodule

// File: hw/psg_mixer.sv
// PSG mixer: attenuated, signed channel amplitudes summed into a registered PCM sample.
module psg_mixer (
	input  logic                                      clk48M,
	input  logic                                      reset,
	input  logic [psg_pkg::NUM_CH-1:0]                polarity,
	input  logic [psg_pkg::NUM_CH*psg_pkg::ATT_W-1:0] atten,
	output logic signed [psg_pkg::SAMPLE_W-1:0]       sample
);

	logic signed [psg_pkg::SAMPLE_W-1:0] mix;  // Next sample.

	//////////////////////////////////////////////////////////////////////
	// Channel sum
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		logic [psg_pkg::AMP_W-1:0]           amp;
		logic signed [psg_pkg::SAMPLE_W-1:0] amp_s;
		mix = '0;
		for (int c = 0; c < psg_pkg::NUM_CH; c++) begin
			amp   = psg_pkg::ATT_LUT[atten[c*psg_pkg::ATT_W +: psg_pkg::ATT_W]];
			amp_s = $signed(psg_pkg::SAMPLE_W'(amp));  // Zero extend.
			if (polarity[c]) begin
				mix = mix + amp_s;  // High half of the wave.
			end else begin
				mix = mix - amp_s;  // Low half.
			end
		end
	end

	// One register between the channels and the PCM output.
	always_ff @(posedge clk48M) begin
		if (reset) begin
			sample <= '0;
		end else begin
			sample <= mix;
		end
	end

endmodule

// File: hw/psg_top.sv
// PSG sound block top: tick generator, APB register file, tone channels and mixer.
module psg_top (
	input  logic                                clk48M,
	input  logic                                reset,
	input  logic                                psel,
	input  logic                                penable,
	input  logic                                pwrite,
	input  logic [psg_pkg::ADDR_W-1:0]          paddr,
	input  logic [psg_pkg::DATA_W-1:0]          pwdata,
	output logic [psg_pkg::DATA_W-1:0]          prdata,
	output logic signed [psg_pkg::SAMPLE_W-1:0] sample
);

	logic                                      tick;      // Tone clock enable.
	logic [psg_pkg::NUM_CH*psg_pkg::PER_W-1:0] period;    // Flat period bus.
	logic [psg_pkg::NUM_CH*psg_pkg::ATT_W-1:0] atten;     // Flat attenuation bus.
	logic [psg_pkg::NUM_CH-1:0]                polarity;  // One bit per channel.

	psg_tick_gen u_tick_gen (
		.clk48M (clk48M),
		.reset  (reset),
		.tick   (tick)
	);

	psg_regs u_regs (
		.clk48M  (clk48M),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.period  (period),
		.atten   (atten)
	);

	//////////////////////////////////////////////////////////////////////
	// Tone channels
	//////////////////////////////////////////////////////////////////////
	genvar g;
	generate
		for (g = 0; g < psg_pkg::NUM_CH; g++) begin : g_tone
			psg_tone u_tone (
				.clk48M   (clk48M),
				.reset    (reset),
				.tick     (tick),
				.period   (period[g*psg_pkg::PER_W +: psg_pkg::PER_W]),
				.polarity (polarity[g])
			);
		end
	endgenerate

	psg_mixer u_mixer (
		.clk48M   (clk48M),
		.reset    (reset),
		.polarity (polarity),
		.atten    (atten),
		.sample   (sample)
	);

endmodule

// File: sim/psg_assert.sv
// PSG assertion checker: APB setup order, tick spacing and silence with every channel muted.
module psg_assert (
	input logic                                      clk48M,
	input logic                                      reset,
	input logic                                      psel,
	input logic                                      penable,
	input logic                                      tick,
	input logic [psg_pkg::NUM_CH*psg_pkg::ATT_W-1:0] atten,
	input logic signed [psg_pkg::SAMPLE_W-1:0]       sample
);

	logic [7:0] since_tick;  // Cycles since the last tick.
	logic       seen_tick;

	always_ff @(posedge clk48M) begin
		if (reset) begin
			since_tick <= '0;
			seen_tick  <= 1'b0;
		end else if (tick) begin
			since_tick <= 8'd1;
			seen_tick  <= 1'b1;
		end else begin
			since_tick <= since_tick + 1'b1;
		end
	end

	// Access cycle only after a setup cycle.
	apb_setup_first: assert property (@(posedge clk48M) disable iff (reset)
		$rose(penable) |-> psel && $past(psel))
		else $error("penable rose without a setup cycle");

	tick_spacing: assert property (@(posedge clk48M) disable iff (reset)
		(tick && seen_tick) |-> since_tick == psg_pkg::TICK_DIV)
		else $error("tick pulses are not TICK_DIV cycles apart");

	silent_when_muted: assert property (@(posedge clk48M) disable iff (reset)
		(&atten) |=> (sample == '0))
		else $error("sample not zero with every channel at attenuation 15");

endmodule

bind psg_top psg_assert u_assert (
	.clk48M  (clk48M),
	.reset   (reset),
	.psel    (psel),
	.penable (penable),
	.tick    (tick),
	.atten   (atten),
	.sample  (sample)
);

// File: sim/psg_tb.sv
// PSG testbench that replays the stimulus file over APB and checks readback, levels and tones.
module psg_tb;

	localparam string STIM_FILE = "sim/psg_stimulus.txt";

	logic                                clk48M;
	logic                                reset;
	logic                                psel;
	logic                                penable;
	logic                                pwrite;
	logic [psg_pkg::ADDR_W-1:0]          paddr;
	logic [psg_pkg::DATA_W-1:0]          pwdata;
	logic [psg_pkg::DATA_W-1:0]          prdata;
	logic signed [psg_pkg::SAMPLE_W-1:0] sample;

	byte unsigned op_q [$];  // Command letters.
	int           a_q  [$];  // First operand.
	int           b_q  [$];  // Second operand of W and R.

	int   errors;
	int   checks;
	int   budget;       // Cycles the file needs.
	int   limit;
	int   cycles;
	logic limit_ready;

	psg_top u_dut (
		.clk48M  (clk48M),
		.reset   (reset),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.sample  (sample)
	);

	initial begin
		clk48M = 1'b0;
		forever #20 clk48M = ~clk48M;
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////
	task automatic check_eq(input logic signed [31:0] got, input logic signed [31:0] exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// Parse the whole file up front so the cycle limit is known.
	task automatic load_stimulus();
		int    fd;
		int    n;
		int    need;
		int    a;
		int    b;
		string line;
		string word;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			$display("Cannot open stimulus file %s", STIM_FILE);
			errors++;
			return;
		end
		while ($fgets(line, fd) > 0) begin
			a = 0;
			b = 0;
			if (line.getc(0) == "#") begin
				continue;  // Comment line.
			end
			n = $sscanf(line, "%s", word);
			if (n < 1) begin
				continue;  // Blank line.
			end
			if (word == "W" || word == "R") begin
				need   = 3;
				n      = $sscanf(line, "%s %h %h", word, a, b);
				budget += 4;
			end else if (word == "L" || word == "H" || word == "C") begin
				need = 2;
				n    = $sscanf(line, "%s %d", word, a);
				if (word == "H") begin
					budget += 3 * a;
				end else if (word == "C") begin
					budget += a;
				end else begin
					budget += 4;
				end
			end else begin
				$display("Unknown command '%s' in stimulus file, line skipped", word);
				errors++;
				continue;
			end
			if (n != need) begin
				$display("Stimulus line '%s' is missing an operand", word);
				errors++;
			end
			op_q.push_back(word.getc(0));
			a_q.push_back(a);
			b_q.push_back(b);
		end
		$fclose(fd);
	endtask

	task automatic apb_write(input int addr, input int data);
		@(negedge clk48M);
		psel    = 1'b1;   // Setup cycle.
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr[psg_pkg::ADDR_W-1:0];
		pwdata  = data[psg_pkg::DATA_W-1:0];
		@(negedge clk48M);
		penable = 1'b1;   // Access cycle.
		@(negedge clk48M);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_read(input int addr, input int exp);
		logic [psg_pkg::DATA_W-1:0] got;
		@(negedge clk48M);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr[psg_pkg::ADDR_W-1:0];
		@(negedge clk48M);
		penable = 1'b1;
		@(posedge clk48M);
		got = prdata;  // Stable since the falling edge.
		@(negedge clk48M);
		psel    = 1'b0;
		penable = 1'b0;
		check_eq(got, exp, $sformatf("read addr 0x%0h", addr));
	endtask

	task automatic check_level(input int exp);
		repeat (4) @(negedge clk48M);
		check_eq(sample, exp, "PCM level");
	endtask

	// Cycles until the sign of sample differs from its value at entry.
	task automatic wait_sign_change(output int n);
		logic sign;
		sign = sample[psg_pkg::SAMPLE_W-1];
		n    = 0;
		do begin
			@(negedge clk48M);
			n++;
		end while (sample[psg_pkg::SAMPLE_W-1] == sign);
	endtask

	task automatic check_half_period(input int exp);
		int n;
		wait_sign_change(n);  // Lock onto the wave.
		wait_sign_change(n);
		wait_sign_change(n);
		check_eq(n, exp, "half period in cycles");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		reset       = 1'b1;
		psel        = 1'b0;
		penable     = 1'b0;
		pwrite      = 1'b0;
		paddr       = '0;
		pwdata      = '0;
		errors      = 0;
		checks      = 0;
		budget      = 2;   // Reset cycles.
		limit_ready = 1'b0;
		load_stimulus();
		limit       = 2 * budget;
		limit_ready = 1'b1;
		repeat (2) @(negedge clk48M);
		reset = 1'b0;
		foreach (op_q[i]) begin
			case (op_q[i])
				"W":     apb_write(a_q[i], b_q[i]);
				"R":     apb_read(a_q[i], b_q[i]);
				"L":     check_level(a_q[i]);
				"H":     check_half_period(a_q[i]);
				default: repeat (a_q[i]) @(negedge clk48M);  // Idle.
			endcase
		end
		repeat (2) @(negedge clk48M);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// Watchdog on the cycle budget.
	initial begin
		cycles = 0;
		wait (limit_ready);
		while (cycles < limit) begin
			@(posedge clk48M);
			cycles++;
		end
		$display("Timeout: test did not finish within %0d cycles", limit);
		$display("sim failed");
		$finish;
	end

endmodule

// File: sim/psg_stimulus.txt
# Columns: op a b. W addr data and R addr expected are hex, L level, H cycles and C count decimal.
# L waits 4 cycles and checks sample, H checks a half period, C idles.
C 4
R 0 00
R 8 00
R 9 f0
R a 00
R b f0
R c 00
R d f0
L 0
# Attenuation with all periods at zero.
W 0 90
L 10922
W 0 b2
L 17813
W 0 d5
L 21267
R 9 00
R b 20
R d 50
R 0 d5
W 0 9f
W 0 bf
W 0 df
L 0
# Periods from latch and data bytes, channel 3 latch ignored.
W 0 85
W 0 01
R 8 15
R 9 f0
R 0 85
W 0 a3
W 0 12
R a 23
R b f1
W 0 c7
W 0 00
R c 07
W 0 e4
R 0 c7
W 0 03
R c 37
R 8 15
R a 23
# Half periods, one channel audible at a time.
W 0 d0
H 2640
W 0 df
W 0 90
H 1008
W 0 9f
W 0 b0
H 13968
W 0 bf
L 0

// File: flist.f
hw/psg_pkg.sv
hw/psg_tick_gen.sv
hw/psg_regs.sv
hw/psg_tone.sv
hw/psg_mixer.sv
hw/psg_top.sv
sim/psg_assert.sv
sim/psg_tb.sv

// File: Makefile
# Verilator build and run for the PSG sound block.

VERILATOR ?= verilator
TOP       ?= psg_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= sim failed
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
